/* project.f */
+incdir+.
raster_geom_pkg.sv
circle_ctl_pkg.sv
pixel_if.sv
circle_dp_if.sv
circle_datapath.sv
circle_fsm.sv
circle.sv
screen_clear.sv
draw_ctrl_wb.sv
draw_top.sv
tb_draw.sv

/* Bender.yml */
package:
  name: raster_draw

sources:
  - include_dirs:
      - .
    files:
      - raster_geom_pkg.sv
      - circle_ctl_pkg.sv
      - pixel_if.sv
      - circle_dp_if.sv
      - circle_datapath.sv
      - circle_fsm.sv
      - circle.sv
      - screen_clear.sv
      - draw_ctrl_wb.sv
      - draw_top.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - tb_draw.sv

/* tb_draw.sv */
`timescale 1ns/1ns
`include "raster_consts.svh"

module tb_draw;
  import circle_ctl_pkg::*;

  localparam int CLEAR_CYCLES = `RASTER_W * `RASTER_H;
  localparam int MAX_CYCLES   = 3 * CLEAR_CYCLES + 2400; // three clears plus circles.
  localparam int MODE_IDLE    = 0;
  localparam int MODE_CLEAR   = 1;
  localparam int MODE_CIRC    = 2;

  logic                      clk;
  logic                      rst;
  logic                      cyc;
  logic                      stb;
  logic                      we;
  logic [`RASTER_ADDR_W-1:0] adr;
  logic [`WB_DW-1:0]         dat_w;
  logic [`WB_DW-1:0]         dat_r;
  logic                      ack;
  logic [7:0]                vga_x;
  logic [6:0]                vga_y;
  logic [2:0]                vga_colour;
  logic                      vga_plot;

  int          errors;
  int          test_errors;
  int          cycles;
  int          mode;
  int          plot_count;
  int          clr_idx;    // next expected raster position.
  int          exp_count;
  logic [2:0]  exp_colour;
  logic        bus_seen;
  logic        model_hit;
  int          pix_index;
  int unsigned rng_state;
  int          hits [0:CLEAR_CYCLES-1]; // remaining expected plots per pixel.

  draw_top #(
    .SEGMENT (SEG_FULL)
  ) UUT (
    .clk        (clk),
    .rst        (rst),
    .cyc        (cyc),
    .stb        (stb),
    .we         (we),
    .adr        (adr),
    .dat_w      (dat_w),
    .dat_r      (dat_r),
    .ack        (ack),
    .vga_x      (vga_x),
    .vga_y      (vga_y),
    .vga_colour (vga_colour),
    .vga_plot   (vga_plot)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  assign pix_index = int'(vga_y) * `RASTER_W + int'(vga_x);
  assign model_hit = (vga_x < `RASTER_W) && (vga_y < `RASTER_H) && (hits[pix_index] > 0);

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (vga_plot) begin
      plot_count = plot_count + 1;
      if (mode == MODE_CLEAR) begin
        clr_idx = clr_idx + 1;
      end
      if (mode == MODE_CIRC && model_hit) begin
        hits[pix_index] = hits[pix_index] - 1; // each model point is used once.
      end
    end
    if (cycles >= MAX_CYCLES) begin
      $display("timeout, run reached the cycle limit of %0d", MAX_CYCLES);
      $display("Something failed");
      $finish;
    end
  end

  a_quiet_after_reset: assert property (@(posedge clk) disable iff (rst)
    !bus_seen |-> !ack && !vga_plot)
    else begin
      errors++;
      $display("ack or vga_plot went high before the first bus access");
    end

  a_ack_follows_req: assert property (@(posedge clk) disable iff (rst)
    (cyc && stb && !ack) |=> ack)
    else begin
      errors++;
      $display("ack did not rise one cycle after the strobe");
    end

  a_ack_single: assert property (@(posedge clk) disable iff (rst) ack |=> !ack)
    else begin
      errors++;
      $display("ack stayed high for two cycles");
    end

  a_ack_on_req: assert property (@(posedge clk) disable iff (rst) ack |-> $past(cyc && stb))
    else begin
      errors++;
      $display("ack rose without a bus request");
    end

  a_plot_in_range: assert property (@(posedge clk) disable iff (rst)
    vga_plot |-> (vga_x < `RASTER_W) && (vga_y < `RASTER_H))
    else begin
      errors++;
      $display("Error: vga_x = 0x%0h, vga_y = 0x%0h, outside the screen",
               $sampled(vga_x), $sampled(vga_y));
    end

  a_clear_colour: assert property (@(posedge clk) disable iff (rst)
    (mode == MODE_CLEAR && vga_plot) |-> vga_colour == 3'd0)
    else begin
      errors++;
      $display("Error: vga_colour = 0x%0h, expected 0x0", $sampled(vga_colour));
    end

  a_clear_order: assert property (@(posedge clk) disable iff (rst)
    (mode == MODE_CLEAR && vga_plot) |->
      (vga_x == clr_idx % `RASTER_W) && (vga_y == clr_idx / `RASTER_W))
    else begin
      errors++;
      $display("Error: vga_x = 0x%0h, vga_y = 0x%0h, expected 0x%0h, 0x%0h",
               $sampled(vga_x), $sampled(vga_y),
               $sampled(clr_idx) % `RASTER_W, $sampled(clr_idx) / `RASTER_W);
    end

  a_circ_colour: assert property (@(posedge clk) disable iff (rst)
    (mode == MODE_CIRC && vga_plot) |-> vga_colour == exp_colour)
    else begin
      errors++;
      $display("Error: vga_colour = 0x%0h, expected 0x%0h",
               $sampled(vga_colour), $sampled(exp_colour));
    end

  a_circ_point: assert property (@(posedge clk) disable iff (rst)
    (mode == MODE_CIRC && vga_plot) |-> model_hit)
    else begin
      errors++;
      $display("Error: vga_x = 0x%0h, vga_y = 0x%0h, not a remaining model point",
               $sampled(vga_x), $sampled(vga_y));
    end

  a_idle_no_plot: assert property (@(posedge clk) disable iff (rst)
    (mode == MODE_IDLE) |-> !vga_plot)
    else begin
      errors++;
      $display("a plot appeared while no drawing command was running");
    end

  // lcg with the upper bits kept.
  function automatic int unsigned next_random(input int unsigned span);
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return (rng_state >> 8) % span;
  endfunction

  // runs from 10 ns after one rising edge to 10 ns after a later one.
  task automatic bus_cycle(input logic write, input logic [`RASTER_ADDR_W-1:0] a,
                           input logic [`WB_DW-1:0] d, output logic [`WB_DW-1:0] q);
    int waited;
    waited   = 0;
    bus_seen = 1'b1;
    cyc      = 1'b1;
    stb      = 1'b1;
    we       = write;
    adr      = a;
    dat_w    = d;
    do begin
      @(posedge clk);
      #10;
      waited++;
    end while (!ack && waited < 8);
    q = dat_r;
    assert (ack) else begin
      errors++;
      $display("no ack for the bus access to register %0d", a);
    end
    @(posedge clk); // request held over the edge that sees ack.
    #10;
    cyc = 1'b0;
    stb = 1'b0;
    we  = 1'b0;
  endtask

  task automatic wb_write(input logic [`RASTER_ADDR_W-1:0] a, input logic [`WB_DW-1:0] d);
    logic [`WB_DW-1:0] unused;
    bus_cycle(1'b1, a, d, unused);
  endtask

  task automatic wb_read(input logic [`RASTER_ADDR_W-1:0] a, output logic [`WB_DW-1:0] q);
    bus_cycle(1'b0, a, '0, q);
  endtask

  task automatic check_value(input string name, input int got, input int exp);
    assert (got == exp) else begin
      errors++;
      $display("Error: %s = 0x%0h, expected 0x%0h", name, got, exp);
    end
  endtask

  task automatic wait_not_busy();
    logic [`WB_DW-1:0] st;
    st = 1;
    while (st[0]) begin
      wb_read(`REG_STATUS, st);
    end
  endtask

  task automatic report_test(input int num, input string name);
    $display("test %0d %s: %0d errors", num, name, errors - test_errors);
    test_errors = errors;
  endtask

  // counts every octant point of the midpoint circle including duplicates.
  task automatic build_model(input int cx, input int cy, input int r);
    int ox;
    int oy;
    int d;
    int k;
    int px;
    int py;
    logic swap;
    for (k = 0; k < CLEAR_CYCLES; k++) begin
      hits[k] = 0;
    end
    exp_count = 0;
    ox = r;
    oy = 0;
    d  = 1 - r;
    while (oy <= ox) begin
      for (k = 0; k < 8; k++) begin
        swap = (k == 1 || k == 2 || k == 5 || k == 6);
        px = cx + ((k >= 2 && k <= 5) ? -1 : 1) * (swap ? oy : ox);
        py = cy + ((k >= 4) ? -1 : 1) * (swap ? ox : oy);
        if (px >= 0 && px < `RASTER_W && py >= 0 && py < `RASTER_H) begin
          hits[py * `RASTER_W + px]++;
          exp_count++;
        end
      end
      oy++;
      if (d > 0) begin
        ox--;
        d = d + 2 * (oy - ox) + 1;
      end else begin
        d = d + 2 * oy + 1;
      end
    end
  endtask

  task automatic draw_circle(input int cx, input int cy, input int r, input int c);
    build_model(cx, cy, r);
    exp_colour = c;
    wb_write(`REG_CX, cx);
    wb_write(`REG_CY, cy);
    wb_write(`REG_RADIUS, r);
    wb_write(`REG_COLOUR, c);
    plot_count = 0;
    mode = MODE_CIRC;
    wb_write(`REG_CTRL, 16'h1);
    wait_not_busy();
    mode = MODE_IDLE;
    check_value("plot_count", plot_count, exp_count);
  endtask

  task automatic start_clear();
    logic [`WB_DW-1:0] st;
    plot_count = 0;
    clr_idx = 0;
    mode = MODE_CLEAR;
    wb_write(`REG_CTRL, 16'h2);
    wb_read(`REG_STATUS, st);
    check_value("busy", st[0], 1);
  endtask

  initial begin
    logic [`WB_DW-1:0] val [0:3];
    logic [`WB_DW-1:0] q;
    int i;
    rst = 1'b1;
    cyc = 1'b0;
    stb = 1'b0;
    we = 1'b0;
    adr = '0;
    dat_w = '0;
    errors = 0;
    test_errors = 0;
    cycles = 0;
    mode = MODE_IDLE;
    plot_count = 0;
    clr_idx = 0;
    exp_count = 0;
    exp_colour = '0;
    bus_seen = 1'b0;
    rng_state = 79033;
    for (i = 0; i < CLEAR_CYCLES; i++) begin
      hits[i] = 0;
    end
    repeat (3) @(posedge clk);
    #10;
    rst = 1'b0;

    repeat (5) @(posedge clk);
    #10;
    wb_read(`REG_STATUS, q);
    check_value("busy", q[0], 0);
    report_test(1, "reset state");

    for (i = 0; i < 4; i++) begin
      val[i] = next_random(65536);
      wb_write(i, val[i]);
    end
    for (i = 0; i < 4; i++) begin
      wb_read(i, q);
      check_value("dat_r", q, val[i]);
    end
    report_test(2, "register readback");

    start_clear();
    wait_not_busy();
    mode = MODE_IDLE;
    check_value("plot_count", plot_count, CLEAR_CYCLES);
    report_test(3, "screen clear");

    draw_circle(40 + next_random(80), 40 + next_random(40), 10 + next_random(26),
                1 + next_random(7));
    report_test(4, "centred circle");

    draw_circle(next_random(8), 112 + next_random(8), 20 + next_random(10),
                1 + next_random(7));
    report_test(5, "clipped circle");

    start_clear();
    wb_write(`REG_CTRL, 16'h1); // ignored while the clear runs.
    wb_read(`REG_STATUS, q);
    check_value("busy", q[0], 1);
    wait_not_busy();
    mode = MODE_IDLE;
    repeat (20) @(posedge clk);
    #10;
    check_value("plot_count", plot_count, CLEAR_CYCLES);
    report_test(6, "control write while busy");

    $display("6 tests done, %0d errors", errors);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

/* draw_top.sv */
`timescale 1ns/1ns
`include "raster_consts.svh"

module draw_top #(
  parameter circle_ctl_pkg::segment_t SEGMENT = circle_ctl_pkg::SEG_FULL
) (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      cyc,
  input  logic                      stb,
  input  logic                      we,
  input  logic [`RASTER_ADDR_W-1:0] adr,
  input  logic [`WB_DW-1:0]         dat_w,
  output logic [`WB_DW-1:0]         dat_r,
  output logic                      ack,
  output raster_geom_pkg::scr_x_t   vga_x,
  output raster_geom_pkg::scr_y_t   vga_y,
  output raster_geom_pkg::colour_t  vga_colour,
  output logic                      vga_plot
);
  import raster_geom_pkg::*;

  coord_t  centre_x;
  coord_t  centre_y;
  coord_t  radius;
  colour_t colour;
  logic    circ_start;
  logic    circ_done;
  logic    clr_start;
  logic    clr_done;

  pixel_if clr_bus ();
  pixel_if circ_bus ();

  draw_ctrl_wb u_ctrl (
    .clk        (clk),
    .rst        (rst),
    .cyc        (cyc),
    .stb        (stb),
    .we         (we),
    .adr        (adr),
    .dat_w      (dat_w),
    .dat_r      (dat_r),
    .ack        (ack),
    .centre_x   (centre_x),
    .centre_y   (centre_y),
    .radius     (radius),
    .colour     (colour),
    .circ_start (circ_start),
    .clr_start  (clr_start),
    .circ_done  (circ_done),
    .clr_done   (clr_done),
    .clr_pix    (clr_bus.dst),
    .circ_pix   (circ_bus.dst),
    .vga_x      (vga_x),
    .vga_y      (vga_y),
    .vga_colour (vga_colour),
    .vga_plot   (vga_plot)
  );

  screen_clear u_clear (
    .clk   (clk),
    .rst   (rst),
    .start (clr_start),
    .done  (clr_done),
    .pix   (clr_bus.src)
  );

  circle #(
    .SEGMENT (SEGMENT)
  ) u_circle (
    .clk      (clk),
    .rst      (rst),
    .start    (circ_start),
    .done     (circ_done),
    .centre_x (centre_x),
    .centre_y (centre_y),
    .radius   (radius),
    .colour   (colour),
    .pix      (circ_bus.src)
  );

endmodule

/* draw_ctrl_wb.sv */
`timescale 1ns/1ns
`include "raster_consts.svh"

module draw_ctrl_wb (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      cyc,
  input  logic                      stb,
  input  logic                      we,
  input  logic [`RASTER_ADDR_W-1:0] adr,
  input  logic [`WB_DW-1:0]         dat_w,
  output logic [`WB_DW-1:0]         dat_r,
  output logic                      ack,
  output raster_geom_pkg::coord_t   centre_x,
  output raster_geom_pkg::coord_t   centre_y,
  output raster_geom_pkg::coord_t   radius,
  output raster_geom_pkg::colour_t  colour,
  output logic                      circ_start,
  output logic                      clr_start,
  input  logic                      circ_done,
  input  logic                      clr_done,
  pixel_if.dst                      clr_pix,
  pixel_if.dst                      circ_pix,
  output raster_geom_pkg::scr_x_t   vga_x,
  output raster_geom_pkg::scr_y_t   vga_y,
  output raster_geom_pkg::colour_t  vga_colour,
  output logic                      vga_plot
);
  import raster_geom_pkg::*;

  logic [`WB_DW-1:0] r_cx;
  logic [`WB_DW-1:0] r_cy;
  logic [`WB_DW-1:0] r_radius;
  logic [`WB_DW-1:0] r_colour;
  logic [`WB_DW-1:0] rd_data;
  logic              bus_req;
  logic              wr_req;
  logic              ctrl_wr;
  logic              busy;
  logic              run_circ; // 1 while the circle engine owns the pixel port.

  assign bus_req = cyc && stb && !ack;
  assign wr_req  = bus_req && we;
  assign ctrl_wr = wr_req && (adr == `REG_CTRL) && !busy;

  always_ff @(posedge clk) begin
    if (rst) begin
      ack        <= 1'b0;
      busy       <= 1'b0;
      run_circ   <= 1'b0;
      circ_start <= 1'b0;
      clr_start  <= 1'b0;
    end else begin
      ack        <= bus_req;
      circ_start <= ctrl_wr && dat_w[0];
      clr_start  <= ctrl_wr && dat_w[1] && !dat_w[0]; // circle wins if both set.
      if (ctrl_wr && (dat_w[0] || dat_w[1])) begin
        busy     <= 1'b1;
        run_circ <= dat_w[0];
      end else if (busy && (run_circ ? circ_done : clr_done)) begin
        busy <= 1'b0;
      end
    end
  end

  always_comb begin
    case (adr)
      `REG_CX:     rd_data = r_cx;
      `REG_CY:     rd_data = r_cy;
      `REG_RADIUS: rd_data = r_radius;
      `REG_COLOUR: rd_data = r_colour;
      `REG_STATUS: rd_data = {{(`WB_DW - 1){1'b0}}, busy};
      default:     rd_data = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (bus_req && !we) begin
      dat_r <= rd_data;
    end
    if (wr_req) begin
      case (adr)
        `REG_CX:     r_cx     <= dat_w;
        `REG_CY:     r_cy     <= dat_w;
        `REG_RADIUS: r_radius <= dat_w;
        `REG_COLOUR: r_colour <= dat_w;
        default: ;
      endcase
    end
  end

  // low bits only, keeps centre plus offset inside coord_t.
  assign centre_x = coord_t'({2'b00, r_cx[7:0]});
  assign centre_y = coord_t'({3'b000, r_cy[6:0]});
  assign radius   = coord_t'({2'b00, r_radius[7:0]});
  assign colour   = r_colour[2:0];

  always_comb begin
    if (run_circ) begin
      vga_x      = circ_pix.x;
      vga_y      = circ_pix.y;
      vga_colour = circ_pix.colour;
      vga_plot   = circ_pix.plot;
    end else begin
      vga_x      = clr_pix.x;
      vga_y      = clr_pix.y;
      vga_colour = clr_pix.colour;
      vga_plot   = clr_pix.plot;
    end
  end

  a_ack_pulse: assert property (@(posedge clk) disable iff (rst) ack |=> !ack);

  // an engine only finishes while this block records it as running.
  a_done_owner: assert property (@(posedge clk) disable iff (rst)
    (circ_done |-> busy && run_circ) and (clr_done |-> busy && !run_circ));

endmodule

/* screen_clear.sv */
`timescale 1ns/1ns
`include "raster_consts.svh"

module screen_clear (
  input  logic clk,
  input  logic rst,
  input  logic start,
  output logic done,
  pixel_if.src pix
);
  import raster_geom_pkg::*;

  scr_x_t cnt_x;
  scr_y_t cnt_y;
  logic   active;

  always_ff @(posedge clk) begin
    if (rst) begin
      cnt_x  <= '0;
      cnt_y  <= '0;
      active <= 1'b0;
      done   <= 1'b0;
    end else begin
      done <= 1'b0;
      if (start && !active) begin
        cnt_x  <= '0;
        cnt_y  <= '0;
        active <= 1'b1;
      end else if (active) begin
        if (cnt_x == scr_x_t'(`RASTER_W - 1)) begin
          cnt_x <= '0;
          if (cnt_y == scr_y_t'(`RASTER_H - 1)) begin
            active <= 1'b0; // last pixel of the frame.
            done   <= 1'b1;
          end else begin
            cnt_y <= cnt_y + 1'b1;
          end
        end else begin
          cnt_x <= cnt_x + 1'b1;
        end
      end
    end
  end

  assign pix.x      = cnt_x;
  assign pix.y      = cnt_y;
  assign pix.colour = '0; // black.
  assign pix.plot   = active;

endmodule

/* circle.sv */
`timescale 1ns/1ns

module circle #(
  parameter circle_ctl_pkg::segment_t SEGMENT = circle_ctl_pkg::SEG_FULL
) (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     start,
  output logic                     done,
  input  raster_geom_pkg::coord_t  centre_x,
  input  raster_geom_pkg::coord_t  centre_y,
  input  raster_geom_pkg::coord_t  radius,
  input  raster_geom_pkg::colour_t colour,
  pixel_if.src                     pix
);

  circle_dp_if dp_bus ();

  circle_fsm #(
    .SEGMENT (SEGMENT)
  ) u_fsm (
    .clk   (clk),
    .rst   (rst),
    .start (start),
    .done  (done),
    .ctl   (dp_bus.ctl)
  );

  circle_datapath u_dp (
    .clk      (clk),
    .rst      (rst),
    .centre_x (centre_x),
    .centre_y (centre_y),
    .radius   (radius),
    .colour   (colour),
    .dp       (dp_bus.dp),
    .pix      (pix)
  );

endmodule

/* circle_fsm.sv */
`timescale 1ns/1ns

module circle_fsm #(
  parameter circle_ctl_pkg::segment_t SEGMENT = circle_ctl_pkg::SEG_FULL
) (
  input  logic     clk,
  input  logic     rst,
  input  logic     start,
  output logic     done,
  circle_dp_if.ctl ctl
);
  import circle_ctl_pkg::*;
  import raster_geom_pkg::*;

  localparam octant_t OCT_FIRST = seg_first(SEGMENT);
  localparam octant_t OCT_LAST  = seg_last(SEGMENT);

  circ_state_t state;
  octant_t     oct;
  logic        step_dec_x;
  coord_t      next_x;
  coord_t      next_y;

  // x steps in when the midpoint lies outside the circle.
  assign step_dec_x = ctl.crit > coord_t'(0);
  assign next_y = ctl.offset_y + coord_t'(1);
  assign next_x = ctl.offset_x - coord_t'(step_dec_x);

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= ST_IDLE;
      oct   <= OCT_FIRST;
    end else begin
      case (state)
        ST_IDLE: begin
          if (start) begin
            state <= ST_INIT;
          end
        end
        ST_INIT: begin
          state <= ST_PLOT;
          oct   <= OCT_FIRST;
        end
        ST_PLOT: begin
          if (oct == OCT_LAST) begin
            state <= ST_STEP;
          end else begin
            oct <= octant_t'(oct + 3'd1);
          end
        end
        ST_STEP: begin
          oct   <= OCT_FIRST;
          state <= (next_y <= next_x) ? ST_PLOT : ST_DONE; // loop while y <= x.
        end
        ST_DONE: begin
          state <= ST_IDLE;
        end
        default: begin
          state <= ST_IDLE;
        end
      endcase
    end
  end

  assign ctl.octant_sel = oct;
  assign ctl.load_init  = (state == ST_INIT);
  assign ctl.plot_en    = (state == ST_PLOT);
  assign ctl.load_next  = (state == ST_STEP);
  assign ctl.load_crit  = (state == ST_STEP);
  assign ctl.inc_y      = (state == ST_STEP);
  assign ctl.dec_x      = (state == ST_STEP) && step_dec_x;
  assign done           = (state == ST_DONE);

  a_load_excl: assert property (@(posedge clk) disable iff (rst)
    !(ctl.load_init && ctl.load_next));

  // the datapath must hold a point of the first octant while plotting.
  a_plot_order: assert property (@(posedge clk) disable iff (rst)
    ctl.plot_en |-> ctl.offset_y <= ctl.offset_x);

endmodule

/* circle_datapath.sv */
`timescale 1ns/1ns
`include "raster_consts.svh"

module circle_datapath (
  input  logic                     clk,
  input  logic                     rst,
  input  raster_geom_pkg::coord_t  centre_x,
  input  raster_geom_pkg::coord_t  centre_y,
  input  raster_geom_pkg::coord_t  radius,
  input  raster_geom_pkg::colour_t colour,
  circle_dp_if.dp                  dp,
  pixel_if.src                     pix
);
  import raster_geom_pkg::*;
  import circle_ctl_pkg::*;

  coord_t off_x;
  coord_t off_y;
  coord_t crit;
  coord_t nx;
  coord_t ny;
  coord_t crit_inc;
  coord_t px;
  coord_t py;
  logic   on_screen;

  assign nx = dp.dec_x ? off_x - coord_t'(1) : off_x;
  assign ny = dp.inc_y ? off_y + coord_t'(1) : off_y;
  assign crit_inc = dp.dec_x ? ny - nx : ny; // criterion uses the stepped offsets.

  always_ff @(posedge clk) begin
    if (rst) begin
      off_x <= '0;
      off_y <= '0;
      crit  <= '0;
    end else if (dp.load_init) begin
      off_x <= radius;
      off_y <= '0;
      crit  <= coord_t'(1) - radius;
    end else begin
      if (dp.load_next) begin
        off_x <= nx;
        off_y <= ny;
      end
      if (dp.load_crit) begin
        crit <= crit + crit_inc + crit_inc + coord_t'(1);
      end
    end
  end

  always_comb begin
    px = centre_x + off_x;
    py = centre_y + off_y;
    case (dp.octant_sel)
      OCT_1: begin
        px = centre_x + off_y;
        py = centre_y + off_x;
      end
      OCT_2: begin
        px = centre_x - off_y;
        py = centre_y + off_x;
      end
      OCT_3: begin
        px = centre_x - off_x;
        py = centre_y + off_y;
      end
      OCT_4: begin
        px = centre_x - off_x;
        py = centre_y - off_y;
      end
      OCT_5: begin
        px = centre_x - off_y;
        py = centre_y - off_x;
      end
      OCT_6: begin
        px = centre_x + off_y;
        py = centre_y - off_x;
      end
      OCT_7: begin
        px = centre_x + off_x;
        py = centre_y - off_y;
      end
      default: ; // OCT_0 keeps the defaults.
    endcase
  end

  // off-screen points are dropped.
  assign on_screen = !px[9] && (px < coord_t'(`RASTER_W)) &&
                     !py[9] && (py < coord_t'(`RASTER_H));

  assign dp.offset_x = off_x;
  assign dp.offset_y = off_y;
  assign dp.crit     = crit;

  assign pix.x      = px[7:0];
  assign pix.y      = py[6:0];
  assign pix.colour = colour;
  assign pix.plot   = dp.plot_en && on_screen;

  a_plot_in_range: assert property (@(posedge clk) disable iff (rst)
    pix.plot |-> (pix.x < `RASTER_W) && (pix.y < `RASTER_H));

endmodule

/* circle_dp_if.sv */
`timescale 1ns/1ns

interface circle_dp_if;
  import circle_ctl_pkg::*;
  import raster_geom_pkg::*;

  octant_t octant_sel;
  logic    load_init;
  logic    load_next;
  logic    dec_x;
  logic    inc_y;
  logic    load_crit;
  logic    plot_en;
  coord_t  offset_x;
  coord_t  offset_y;
  coord_t  crit;

  modport ctl (
    output octant_sel,
    output load_init,
    output load_next,
    output dec_x,
    output inc_y,
    output load_crit,
    output plot_en,
    input  offset_x,
    input  offset_y,
    input  crit
  );

  modport dp (
    input  octant_sel,
    input  load_init,
    input  load_next,
    input  dec_x,
    input  inc_y,
    input  load_crit,
    input  plot_en,
    output offset_x,
    output offset_y,
    output crit
  );

endinterface

/* pixel_if.sv */
`timescale 1ns/1ns

interface pixel_if;
  import raster_geom_pkg::*;

  scr_x_t  x;
  scr_y_t  y;
  colour_t colour;
  logic    plot; // one-cycle write strobe.

  modport src (
    output x,
    output y,
    output colour,
    output plot
  );

  modport dst (
    input x,
    input y,
    input colour,
    input plot
  );

endinterface

/* circle_ctl_pkg.sv */
package circle_ctl_pkg;

  // pixel = centre + mapped offsets, screen y grows downward.
  typedef enum logic [2:0] {
    OCT_0, // x + ox, y + oy.
    OCT_1, // x + oy, y + ox.
    OCT_2, // x - oy, y + ox.
    OCT_3, // x - ox, y + oy.
    OCT_4, // x - ox, y - oy.
    OCT_5, // x - oy, y - ox.
    OCT_6, // x + oy, y - ox.
    OCT_7  // x + ox, y - oy.
  } octant_t;

  typedef enum logic [1:0] {
    SEG_FULL,        // octants 0 to 7.
    SEG_LOWER,       // octants 0 to 3.
    SEG_UPPER_LEFT,  // octants 4 and 5.
    SEG_UPPER_RIGHT  // octants 6 and 7.
  } segment_t;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_INIT,
    ST_PLOT,
    ST_STEP,
    ST_DONE
  } circ_state_t;

  // each segment covers a contiguous run of octants.
  function automatic octant_t seg_first(segment_t seg);
    case (seg)
      SEG_UPPER_LEFT:  return OCT_4;
      SEG_UPPER_RIGHT: return OCT_6;
      default:         return OCT_0;
    endcase
  endfunction

  function automatic octant_t seg_last(segment_t seg);
    case (seg)
      SEG_LOWER:      return OCT_3;
      SEG_UPPER_LEFT: return OCT_5;
      default:        return OCT_7;
    endcase
  endfunction

endpackage

/* raster_geom_pkg.sv */
package raster_geom_pkg;

  // screen column, 0 to 159.
  typedef logic [7:0] scr_x_t;

  // screen row, 0 to 119.
  typedef logic [6:0] scr_y_t;

  // centre plus or minus offset, may fall off screen.
  typedef logic signed [9:0] coord_t;

  // 3-bit rgb.
  typedef logic [2:0] colour_t;

endpackage

/* raster_consts.svh */
`ifndef RASTER_CONSTS_SVH
`define RASTER_CONSTS_SVH

// screen size in pixels.
`define RASTER_W 160
`define RASTER_H 120

// wishbone word address and data widths.
`define RASTER_ADDR_W 3
`define WB_DW 16

// register map.
`define REG_CX     3'd0
`define REG_CY     3'd1
`define REG_RADIUS 3'd2
`define REG_COLOUR 3'd3
`define REG_CTRL   3'd4
`define REG_STATUS 3'd5

`endif
